/* snoop_pkg.sv */
`default_nettype none

package snoop_pkg;

    // bus and cache geometry, all in words
    localparam int address_width    = 32;
    localparam int data_width       = 32;
    localparam int line_offset_bits = 2;
    localparam int line_words       = 4;
    localparam int index_bits       = 8;
    localparam int tag_bits         = address_width - index_bits - line_offset_bits;
    localparam int msg_bits         = 4;

    // messages seen on the shared bus and the L1 interface
    typedef enum logic [msg_bits-1:0] {
        no_req    = 4'd0,
        r_req     = 4'd1,
        rfo_bcast = 4'd2,
        ws_bcast  = 4'd3,
        flush_s   = 4'd4,
        req_flush = 4'd5,
        c_wb      = 4'd6,
        c_flush   = 4'd7,
        en_access = 4'd8,
        mem_resp  = 4'd9
    } msg_t;

    // MESI style line state
    typedef enum logic [1:0] {
        invalid   = 2'd0,
        shared    = 2'd1,
        exclusive = 2'd2,
        modified  = 2'd3
    } coh_t;

    typedef logic [data_width*line_words-1:0] line_t;

    typedef struct packed {
        logic [tag_bits-1:0]         tag;
        logic [index_bits-1:0]       index;
        logic [line_offset_bits-1:0] offset;
    } addr_fields_t;

    // snooped address, flat for the bus and split for the cache lookup
    typedef union packed {
        logic [address_width-1:0] flat;
        addr_fields_t             fields;
    } word_addr_u;

    typedef struct packed {
        msg_t       msg;
        word_addr_u address;
    } bus_req_t;

    // dirty sits in the low bit
    typedef struct packed {
        logic valid;
        logic dirty;
    } line_status_t;

    typedef struct packed {
        line_status_t status;
        coh_t         coh;
    } line_meta_t;

    typedef struct packed {
        msg_t                     msg;
        logic [address_width-1:0] address;
    } snoop_resp_t;

    typedef struct packed {
        msg_t resp_msg;
        logic invalidate;
        logic downgrade;
        // respond with the line base instead of the snooped word
        logic aligned_address;
    } snoop_action_t;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic                  invalidate;
        logic [index_bits-1:0] index;
        logic [tag_bits-1:0]   tag;
        line_meta_t            meta;
    } cache_cmd_t;

endpackage

`default_nettype wire

/* bus_request_decoder.sv */
`default_nettype none

module bus_request_decoder (
    input  logic                                clock,
    input  logic                                reset,
    input  snoop_pkg::msg_t                     bus_msg,
    input  logic [snoop_pkg::address_width-1:0] bus_address,
    input  logic                                bus_master,
    input  logic                                req_ready,
    input  logic                                accept,
    output logic                                request_valid,
    output snoop_pkg::bus_req_t                 request
);

    import snoop_pkg::*;

    logic       snooped_msg;
    msg_t       msg_q;
    word_addr_u address_q;

    // messages that another master sends and this cache must look at
    always_comb begin
        case (bus_msg)
            r_req,
            rfo_bcast,
            ws_bcast,
            flush_s: snooped_msg = 1'b1;
            default: snooped_msg = 1'b0;
        endcase
    end

    // only while someone else owns the bus and the transfer is still pending,
    // a forced flush is always honoured
    assign request_valid = (bus_msg == req_flush)
                         || (snooped_msg && !bus_master && !req_ready);

    always_ff @(posedge clock) begin
        if (reset) begin
            msg_q <= no_req;
        end else if (accept) begin
            msg_q <= bus_msg;
        end
    end

    // address is payload, meaningful only once msg_q is set
    always_ff @(posedge clock) begin
        if (accept) begin
            address_q.flat <= bus_address;
        end
    end

    assign request = '{msg: msg_q, address: address_q};

    // controller must only take what this block has qualified
    accept_needs_valid: assert property (
        @(posedge clock) disable iff (reset)
        accept |-> request_valid
    ) else $error("accept raised without a valid snooped request");

endmodule

`default_nettype wire

/* snoop_action_decoder.sv */
`default_nettype none

module snoop_action_decoder (
    input  snoop_pkg::bus_req_t      request,
    input  logic                     hit,
    input  snoop_pkg::line_status_t  line_status,
    output snoop_pkg::snoop_action_t action
);

    import snoop_pkg::*;

    always_comb begin
        // miss: nothing to do but let the requester go ahead
        action.resp_msg        = en_access;
        action.invalidate      = 1'b0;
        action.downgrade       = 1'b0;
        action.aligned_address = 1'b0;

        if (hit) begin
            if (line_status.dirty) begin
                case (request.msg)
                    r_req: begin
                        // owner supplies the line, memory gets it back
                        action.resp_msg        = c_wb;
                        action.invalidate      = 1'b1;
                        action.aligned_address = 1'b1;
                    end
                    flush_s,
                    req_flush: begin
                        action.resp_msg        = c_flush;
                        action.invalidate      = 1'b1;
                        action.aligned_address = 1'b1;
                    end
                    default: begin
                        // ownership requests drop the dirty copy
                        action.invalidate = 1'b1;
                    end
                endcase
            end else if (request.msg == r_req) begin
                // clean read hit keeps a shared copy
                action.downgrade = 1'b1;
            end else begin
                action.invalidate = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* snoop_controller.sv */
`default_nettype none

module snoop_controller #(
    parameter int num_ways = 4,
    localparam int way_bits = (num_ways > 1) ? $clog2(num_ways) : 1
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     request_valid,
    input  snoop_pkg::bus_req_t      request,
    input  snoop_pkg::snoop_action_t action,
    input  logic [way_bits-1:0]      matched_way,
    input  snoop_pkg::line_t         cache_data_in,
    input  snoop_pkg::msg_t          intf_msg,
    input  logic                     req_ready,
    output logic                     accept,
    output snoop_pkg::cache_cmd_t    cache_cmd,
    output snoop_pkg::line_t         cache_data_out,
    output logic [way_bits-1:0]      way_select,
    output snoop_pkg::snoop_resp_t   snoop_resp,
    output snoop_pkg::line_t         snoop_data
);

    import snoop_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_read_line,
        st_action,
        st_write_line,
        st_wait_for_resp
    } state_t;

    state_t                state;
    logic                  read_q;
    logic                  write_q;
    logic                  invalidate_q;
    logic [index_bits-1:0] cmd_index;
    logic [tag_bits-1:0]   cmd_tag;
    line_meta_t            cmd_meta;
    word_addr_u            line_address;

    // base of the line holding the snooped word
    always_comb begin
        line_address               = request.address;
        line_address.fields.offset = '0;
    end

    // one cycle strobe, the state leaves idle on the same edge
    assign accept = (state == st_idle) && request_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= st_idle;
            read_q       <= 1'b0;
            write_q      <= 1'b0;
            invalidate_q <= 1'b0;
            snoop_resp   <= '{msg: no_req, address: '0};
            snoop_data   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    read_q <= 1'b1;
                    state  <= st_read_line;
                end
                st_read_line: begin
                    // cache answers two edges after read rises
                    state <= st_action;
                end
                st_action: begin
                    read_q <= 1'b0;
                    if (action.downgrade) begin
                        write_q <= 1'b1;
                        state   <= st_write_line;
                    end else begin
                        invalidate_q   <= action.invalidate;
                        snoop_resp.msg <= action.resp_msg;
                        if (action.aligned_address) begin
                            snoop_resp.address <= line_address.flat;
                            snoop_data         <= cache_data_in;
                        end else begin
                            snoop_resp.address <= request.address.flat;
                            snoop_data         <= '0;
                        end
                        state <= st_wait_for_resp;
                    end
                end
                st_write_line: begin
                    write_q    <= 1'b0;
                    snoop_resp <= '{msg: en_access, address: request.address.flat};
                    state      <= st_wait_for_resp;
                end
                st_wait_for_resp: begin
                    invalidate_q <= 1'b0;
                    // memory has the line now, grant the requester
                    if (intf_msg == mem_resp) begin
                        snoop_resp <= '{msg: en_access, address: request.address.flat};
                        snoop_data <= '0;
                    end else if (req_ready) begin
                        snoop_resp <= '{msg: no_req, address: '0};
                        snoop_data <= '0;
                        state      <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // lookup address, downgrade meta and line copy
    always_ff @(posedge clock) begin
        if (state == st_start) begin
            cmd_index <= request.address.fields.index;
            cmd_tag   <= request.address.fields.tag;
        end
        if (state == st_action) begin
            way_select <= matched_way;
            if (action.downgrade) begin
                cmd_meta       <= '{status: '{valid: 1'b1, dirty: 1'b0}, coh: shared};
                cache_data_out <= cache_data_in;
            end
        end
    end

    assign cache_cmd = '{
        read:       read_q,
        write:      write_q,
        invalidate: invalidate_q,
        index:      cmd_index,
        tag:        cmd_tag,
        meta:       cmd_meta
    };

    no_read_write_overlap: assert property (
        @(posedge clock) disable iff (reset)
        !(cache_cmd.read && cache_cmd.write)
    ) else $error("cache read and write strobes overlap");

    invalidate_single_cycle: assert property (
        @(posedge clock) disable iff (reset)
        cache_cmd.invalidate |=> !cache_cmd.invalidate
    ) else $error("cache invalidate held for more than one cycle");

endmodule

`default_nettype wire

/* snooper.sv */
`default_nettype none

module snooper #(
    parameter int num_ways = 4,
    localparam int way_bits = (num_ways > 1) ? $clog2(num_ways) : 1
) (
    input  logic                                clock,
    input  logic                                reset,
    // shared bus
    input  snoop_pkg::msg_t                     bus_msg,
    input  logic [snoop_pkg::address_width-1:0] bus_address,
    input  logic                                bus_master,
    input  logic                                req_ready,
    // cache probe results
    input  logic                                hit,
    input  logic [way_bits-1:0]                 matched_way,
    input  snoop_pkg::line_status_t             line_status,
    input  snoop_pkg::line_t                    cache_data_in,
    // L1 interface
    input  snoop_pkg::msg_t                     intf_msg,
    output snoop_pkg::cache_cmd_t               cache_cmd,
    output snoop_pkg::line_t                    cache_data_out,
    output logic [way_bits-1:0]                 way_select,
    output snoop_pkg::snoop_resp_t              snoop_resp,
    output snoop_pkg::line_t                    snoop_data
);

    import snoop_pkg::*;

    logic          request_valid;
    logic          accept;
    bus_req_t      request;
    snoop_action_t action;

    bus_request_decoder request_decoder0 (
        .clock         (clock),
        .reset         (reset),
        .bus_msg       (bus_msg),
        .bus_address   (bus_address),
        .bus_master    (bus_master),
        .req_ready     (req_ready),
        .accept        (accept),
        .request_valid (request_valid),
        .request       (request)
    );

    snoop_action_decoder action_decoder0 (
        .request     (request),
        .hit         (hit),
        .line_status (line_status),
        .action      (action)
    );

    snoop_controller #(
        .num_ways (num_ways)
    ) controller0 (
        .clock          (clock),
        .reset          (reset),
        .request_valid  (request_valid),
        .request        (request),
        .action         (action),
        .matched_way    (matched_way),
        .cache_data_in  (cache_data_in),
        .intf_msg       (intf_msg),
        .req_ready      (req_ready),
        .accept         (accept),
        .cache_cmd      (cache_cmd),
        .cache_data_out (cache_data_out),
        .way_select     (way_select),
        .snoop_resp     (snoop_resp),
        .snoop_data     (snoop_data)
    );

endmodule

`default_nettype wire

/* snooper_tb_cases.svh */
// snooped transactions applied in order by the testbench loop
localparam int num_cases = 16;

// columns: row, name, bus msg, bus master, hit, dirty, expected response msg,
// expected cache strobe at the outcome edge, mem_resp follows
task automatic load_case_table();
    add_case(0, "rd_clean_hit", r_req, 1'b0, 1'b1, 1'b0, en_access, strobe_write, 1'b0);
    add_case(1, "rd_dirty_hit", r_req, 1'b0, 1'b1, 1'b1, c_wb, strobe_inval, 1'b1);
    add_case(2, "rd_miss", r_req, 1'b0, 1'b0, 1'b0, en_access, strobe_none, 1'b0);
    add_case(3, "rfo_clean_hit", rfo_bcast, 1'b0, 1'b1, 1'b0, en_access, strobe_inval, 1'b0);
    add_case(4, "rd_bus_owned", r_req, 1'b1, 1'b1, 1'b0, no_req, strobe_none, 1'b0);
    add_case(5, "rfo_dirty_hit", rfo_bcast, 1'b0, 1'b1, 1'b1, en_access, strobe_inval, 1'b0);
    add_case(6, "ws_clean_hit", ws_bcast, 1'b0, 1'b1, 1'b0, en_access, strobe_inval, 1'b0);
    add_case(7, "idle_bus", no_req, 1'b0, 1'b1, 1'b1, no_req, strobe_none, 1'b0);
    add_case(8, "fls_clean_hit", flush_s, 1'b0, 1'b1, 1'b0, en_access, strobe_inval, 1'b0);
    add_case(9, "fls_dirty_hit", flush_s, 1'b0, 1'b1, 1'b1, c_flush, strobe_inval, 1'b1);
    add_case(10, "grant_on_bus", en_access, 1'b0, 1'b1, 1'b0, no_req, strobe_none, 1'b0);
    add_case(11, "rfl_dirty_hit", req_flush, 1'b0, 1'b1, 1'b1, c_flush, strobe_inval, 1'b1);
    add_case(12, "rfl_owned_bus", req_flush, 1'b1, 1'b1, 1'b0, en_access, strobe_inval, 1'b0);
    add_case(13, "ws_miss", ws_bcast, 1'b0, 1'b0, 1'b1, en_access, strobe_none, 1'b0);
    add_case(14, "wb_no_mem_resp", r_req, 1'b0, 1'b1, 1'b1, c_wb, strobe_inval, 1'b0);
    add_case(15, "rd_clean_again", r_req, 1'b0, 1'b1, 1'b0, en_access, strobe_write, 1'b0);
endtask

/* snooper_tb.sv */
`default_nettype none

module snooper_tb;

    import snoop_pkg::*;

    localparam int num_ways     = 4;
    localparam int clock_period = 20;
    localparam int reset_cycles = 8;

    typedef enum logic [1:0] {
        strobe_none,
        strobe_write,
        strobe_inval
    } strobe_t;

    typedef struct packed {
        msg_t    msg;
        logic    master;
        logic    hit;
        logic    dirty;
        msg_t    expect_msg;
        strobe_t strobe;
        logic    mem_follows;
    } row_t;

    `include "snooper_tb_cases.svh"

    logic         clock;
    logic         reset;
    msg_t         bus_msg;
    logic [31:0]  bus_address;
    logic         bus_master;
    logic         req_ready;
    logic         hit;
    logic [1:0]   matched_way;
    line_status_t line_status;
    line_t        cache_data_in;
    msg_t         intf_msg;
    cache_cmd_t   cache_cmd;
    line_t        cache_data_out;
    logic [1:0]   way_select;
    snoop_resp_t  snoop_resp;
    line_t        snoop_data;

    row_t         case_table [num_cases];
    string        case_names [num_cases];
    logic [15:0]  lfsr_state = 16'd17747;
    int           error_count;
    int           check_count;

    snooper #(.num_ways(num_ways)) dut0 (.*);

    always #(clock_period / 2) clock = ~clock;

    // 16 bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [127:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[126:0], lfsr_state[0]};
        end
    endtask

    task automatic add_case(input int index, input string name, input msg_t msg,
                            input logic master, input logic hit_bit, input logic dirty,
                            input msg_t expect_msg, input strobe_t strobe,
                            input logic mem_follows);
        case_table[index] = '{msg, master, hit_bit, dirty, expect_msg, strobe, mem_follows};
        case_names[index] = name;
    endtask

    task automatic check_value(input string label, input logic [127:0] expected,
                               input logic [127:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", label, expected, actual);
        end
    endtask

    task automatic run_row(input string name, input row_t row);
        logic [127:0] rnd;
        logic [31:0]  addr;
        line_t        line;
        logic [1:0]   way;
        logic         aligned;
        logic [35:0]  outcome;
        int           cycles;
        take_bits(32, rnd);
        addr = rnd[31:0];
        take_bits(128, line);
        take_bits(2, rnd);
        way = rnd[1:0];
        // writeback and flush answer with the line base and carry the line
        aligned = (row.expect_msg == c_wb) || (row.expect_msg == c_flush);
        outcome = {row.expect_msg, aligned ? {addr[31:2], 2'b00} : addr};

        // cache model holds its answer for the whole transaction
        @(posedge clock);
        bus_msg       <= row.msg;
        bus_address   <= addr;
        bus_master    <= row.master;
        hit           <= row.hit;
        line_status   <= '{valid: 1'b1, dirty: row.dirty};
        matched_way   <= way;
        cache_data_in <= line;

        if (row.expect_msg == no_req) begin
            repeat (6) begin
                @(negedge clock);
                check_value({name, " ignored read"}, 128'(1'b0), 128'(cache_cmd.read));
            end
            @(posedge clock);
            bus_msg    <= no_req;
            bus_master <= 1'b0;
        end else begin
            // edge 0 takes the request
            @(posedge clock);
            bus_msg    <= no_req;
            bus_master <= 1'b0;
            @(negedge clock);
            check_value({name, " read edge 0"}, 128'(1'b0), 128'(cache_cmd.read));
            @(negedge clock);
            check_value({name, " read edge 1"}, 128'(1'b1), 128'(cache_cmd.read));
            check_value({name, " index"}, 128'(addr[9:2]), 128'(cache_cmd.index));
            check_value({name, " tag"}, 128'(addr[31:10]), 128'(cache_cmd.tag));
            @(negedge clock);
            check_value({name, " read edge 2"}, 128'(1'b1), 128'(cache_cmd.read));
            @(negedge clock);
            check_value({name, " read edge 3"}, 128'(1'b0), 128'(cache_cmd.read));
            check_value({name, " way"}, 128'(way), 128'(way_select));
            check_value({name, " write"}, 128'(row.strobe == strobe_write),
                        128'(cache_cmd.write));
            check_value({name, " invalidate"}, 128'(row.strobe == strobe_inval),
                        128'(cache_cmd.invalidate));
            if (row.strobe == strobe_write) begin
                check_value({name, " meta"}, 128'({1'b1, 1'b0, shared}), 128'(cache_cmd.meta));
                check_value({name, " write data"}, line, cache_data_out);
                check_value({name, " early resp"}, 128'(no_req), 128'(snoop_resp.msg));
            end else begin
                check_value({name, " outcome"}, 128'(outcome), 128'(snoop_resp));
                check_value({name, " snoop data"}, aligned ? line : '0, snoop_data);
            end
            @(posedge clock);
            if (row.mem_follows) begin
                intf_msg <= mem_resp;
            end
            @(negedge clock);
            check_value({name, " write edge 4"}, 128'(1'b0), 128'(cache_cmd.write));
            check_value({name, " inval edge 4"}, 128'(1'b0), 128'(cache_cmd.invalidate));
            check_value({name, " resp edge 4"}, 128'(outcome), 128'(snoop_resp));
            if (row.mem_follows) begin
                @(posedge clock);
                intf_msg <= no_req;
                outcome = {en_access, addr};
                @(negedge clock);
                check_value({name, " after mem_resp"}, 128'(outcome), 128'(snoop_resp));
            end
            // response must hold under back-pressure
            repeat (3) begin
                @(negedge clock);
                check_value({name, " held resp"}, 128'(outcome), 128'(snoop_resp));
            end
            @(posedge clock);
            req_ready <= 1'b1;
            cycles = 0;
            do begin
                @(negedge clock);
                cycles++;
            end while ((snoop_resp.msg != no_req) && (cycles < 4));
            if (snoop_resp.msg != no_req) begin
                error_count++;
                $display("%s: snooper did not return to idle after req_ready", name);
            end
            check_value({name, " idle resp"}, 128'(36'd0), 128'(snoop_resp));
            check_value({name, " idle data"}, 128'(0), snoop_data);
            @(posedge clock);
            req_ready <= 1'b0;
        end
    endtask

    initial begin
        int row_index;
        clock         = 1'b0;
        reset         = 1'b1;
        bus_msg       = no_req;
        bus_address   = '0;
        bus_master    = 1'b0;
        req_ready     = 1'b0;
        hit           = 1'b0;
        matched_way   = '0;
        line_status   = '0;
        cache_data_in = '0;
        intf_msg      = no_req;
        error_count   = 0;
        check_count   = 0;
        load_case_table();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("reset strobes", 128'(3'b000),
                    128'({cache_cmd.read, cache_cmd.write, cache_cmd.invalidate}));
        check_value("reset response", 128'(36'd0), 128'(snoop_resp));
        check_value("reset data", 128'(0), snoop_data);
        for (row_index = 0; row_index < num_cases; row_index++) begin
            run_row(case_names[row_index], case_table[row_index]);
        end
        $display("%0d checks run, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // generous budget of 40 cycles per table row
    initial begin
        #(clock_period * (reset_cycles + num_cases * 40));
        $display("watchdog expired, the run took longer than its cycle budget");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
snoop_pkg.sv
bus_request_decoder.sv
snoop_action_decoder.sv
snoop_controller.sv
snooper.sv
snooper_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module snooper_tb -f verilog.f -o snooper_sim

./obj_dir/snooper_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
